// File: game_step.f
common/game_pkg.sv
design/step_control.sv
design/player_action.sv
design/object_lane.sv
design/collision/collision_score.sv
design/game_step.sv
sim/tb_game_step.sv

// File: run_sim.sh
#!/bin/sh
# build and run the game_step testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_game_step \
    -f game_step.f --Mdir obj_dir -o tb_game_step
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_game_step > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
echo "pass message missing from sim.log"
exit 1

// File: sim/tb_game_step.sv
`timescale 1ns/1ns

module tb_game_step;
    import game_pkg::*;

    localparam int NB       = 5;
    localparam int NE       = 5;
    localparam int ND       = 5;
    localparam int N_RANDOM = 200;
    localparam int N_STEPS  = N_RANDOM + 40;   // directed steps on top

    logic          i_clk = 1'b0;
    logic          i_rstn;
    logic          i_start;
    act_e          i_act;
    player_t       i_player;
    obj_t [NB-1:0] i_bullets;
    obj_t [NE-1:0] i_enemies;
    obj_t [ND-1:0] i_divers;
    logic [31:0]   i_score;
    player_t       o_player;
    obj_t [NB-1:0] o_bullets;
    obj_t [NE-1:0] o_enemies;
    obj_t [ND-1:0] o_divers;
    logic [31:0]   o_score;
    logic          o_done;
    logic          o_valid;

    // reference results of the step in flight
    player_t       exp_player  = '0;
    obj_t [NB-1:0] exp_bullets = '0;
    obj_t [NE-1:0] exp_enemies = '0;
    obj_t [ND-1:0] exp_divers  = '0;
    logic [31:0]   exp_score   = '0;
    logic          exp_done    = 1'b0;

    logic [31:0]   rng = 32'd84815;

    game_step #(.N_BULLETS(NB), .N_ENEMIES(NE), .N_DIVERS(ND)) game_step_i (
        .i_clk(i_clk), .i_rstn(i_rstn), .i_start(i_start), .i_act(i_act),
        .i_player(i_player), .i_bullets(i_bullets), .i_enemies(i_enemies),
        .i_divers(i_divers), .i_score(i_score), .o_player(o_player),
        .o_bullets(o_bullets), .o_enemies(o_enemies), .o_divers(o_divers),
        .o_score(o_score), .o_done(o_done), .o_valid(o_valid)
    );

    always #5 i_clk = ~i_clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic obj_t mk_obj(input int x, input int y, input bit dir, input bit act);
        obj_t o;
        o.x      = 8'(x);
        o.y      = 8'(y);
        o.dir    = dir;
        o.active = act;
        return o;
    endfunction

    // random object near the player so overlaps are common
    function automatic obj_t near_obj(input player_t p);
        obj_t        o;
        logic [31:0] r;
        r        = xorshift32();
        o.x      = p.x + 8'(r[4:0]) - 8'd16;
        o.y      = p.y + 8'(r[12:8]) - 8'd16;
        o.dir    = r[16];
        o.active = r[20] | r[21];
        return o;
    endfunction

    // one pixel of travel and gone once past an edge
    function automatic obj_t travel(input obj_t o);
        obj_t n;
        n = o;
        if (o.active && o.dir) begin
            if (o.x == 8'd0) n.active = 1'b0;
            else n.x = o.x - 8'd1;
        end else if (o.active) begin
            if (int'(o.x) >= SCREEN_WIDTH) n.active = 1'b0;
            else n.x = o.x + 8'd1;
        end
        return n;
    endfunction

    function automatic bit hits_enemy(input obj_t bl, input obj_t en);
        return int'(bl.x) > int'(en.x) && int'(bl.x) < int'(en.x) + ENEMY_SIZE
            && int'(bl.y) > int'(en.y) && int'(bl.y) < int'(en.y) + ENEMY_SIZE;
    endfunction

    task automatic predict();
        player_t       p;
        obj_t [NB-1:0] b;
        obj_t [NE-1:0] e;
        obj_t [ND-1:0] d;
        int            gain;
        int            slot;
        logic [2:0]    held;
        p    = i_player;
        gain = 0;
        slot = -1;
        case (i_act)
            ACT_LEFT:  if (p.x != 8'd0) p.x = p.x - 8'd1;
            ACT_RIGHT: if (int'(p.x) + PLAYER_SIZE < SCREEN_WIDTH) p.x = p.x + 8'd1;
            ACT_UP:    if (p.y != 8'd0) p.y = p.y - 8'd1;
            ACT_DOWN:  if (int'(p.y) + PLAYER_SIZE < SCREEN_HEIGHT) p.y = p.y + 8'd1;
            default:   p = i_player;
        endcase
        for (int k = 0; k < NB; k++) b[k] = travel(i_bullets[k]);
        for (int k = 0; k < NE; k++) e[k] = travel(i_enemies[k]);
        for (int k = 0; k < ND; k++) d[k] = travel(i_divers[k]);
        for (int k = NB - 1; k >= 0; k--) begin
            if (!i_bullets[k].active) slot = k;
        end
        // two pixels beside the player, kept to 8 bits
        if (i_act == ACT_FIRE_LEFT && slot >= 0) begin
            b[slot] = mk_obj(int'(i_player.x) - 2, i_player.y, 1'b1, 1'b1);
        end else if (i_act == ACT_FIRE_RIGHT && slot >= 0) begin
            b[slot] = mk_obj(int'(i_player.x) + 2, i_player.y, 1'b0, 1'b1);
        end
        for (int n = 0; n < NE; n++) begin
            for (int k = 0; k < NB; k++) begin
                if (e[n].active && b[k].active && hits_enemy(b[k], e[n])) begin
                    e[n].active = 1'b0;
                    b[k].active = 1'b0;
                    gain += SHOT_REWARD;
                end
            end
        end
        held = p.divc;
        for (int k = 0; k < ND; k++) begin
            if (d[k].active && d[k].x >= p.x && int'(d[k].x) < int'(p.x) + PLAYER_SIZE
                    && d[k].y >= p.y && int'(d[k].y) < int'(p.y) + PLAYER_SIZE) begin
                d[k].active = 1'b0;
                gain += DIVER_REWARD;
                if (p.divc < 3'(MAX_DIVERS_HELD)) p.divc = p.divc + 3'd1;
            end
        end
        if (int'(p.y) < SURFACE_Y) begin
            p.oxygen = 10'(MAX_OXYGEN);
            if (held == 3'(MAX_DIVERS_HELD)) begin
                p.divc = 3'd0;
                gain += RESCUE_REWARD;
            end
        end else if (p.oxygen <= 10'd1) begin
            p.oxygen = 10'(MAX_OXYGEN);
            if (p.lives <= 3'd1) begin
                p.lives  = 3'd0;
                exp_done = 1'b1;
            end else begin
                p.lives = p.lives - 3'd1;
            end
        end else begin
            p.oxygen = p.oxygen - 10'd1;
        end
        exp_player  = p;
        exp_bullets = b;
        exp_enemies = e;
        exp_divers  = d;
        exp_score   = i_score + 32'(gain);
    endtask

    // called right after a falling edge
    task automatic run_step(input act_e act);
        int waited = 0;
        i_act = act;
        predict();
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        while (!o_valid) begin
            @(negedge i_clk);
            waited++;
            if (waited > 8) fail_now("o_valid never came after start");
        end
        @(negedge i_clk); // expected values stay put through the checking edge
    endtask

    task automatic set_base();
        i_player.x      = 8'd100;
        i_player.y      = 8'd80;
        i_player.oxygen = 10'd500;
        i_player.lives  = 3'd3;
        i_player.divc   = 3'd0;
        i_bullets       = '0;
        i_enemies       = '0;
        i_divers        = '0;
        i_score         = 32'h0000_1000;
    endtask

    chk_valid: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_valid == $past(i_start, 2))
        else fail_now("o_valid not exactly two cycles after start");

    chk_player: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_valid |-> o_player == exp_player)
        else fail_now($sformatf("Mismatch o_player: got %h, expected %h",
            $sampled(o_player), exp_player));

    chk_bullets: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_valid |-> o_bullets == exp_bullets)
        else fail_now($sformatf("Mismatch o_bullets: got %h, expected %h",
            $sampled(o_bullets), exp_bullets));

    chk_enemies: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_valid |-> o_enemies == exp_enemies)
        else fail_now($sformatf("Mismatch o_enemies: got %h, expected %h",
            $sampled(o_enemies), exp_enemies));

    chk_divers: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_valid |-> o_divers == exp_divers)
        else fail_now($sformatf("Mismatch o_divers: got %h, expected %h",
            $sampled(o_divers), exp_divers));

    chk_score: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_valid |-> o_score == exp_score)
        else fail_now($sformatf("Mismatch o_score: got %h, expected %h",
            $sampled(o_score), exp_score));

    chk_done: assert property (@(posedge i_clk) disable iff (!i_rstn)
            o_valid |-> o_done == exp_done)
        else fail_now($sformatf("Mismatch o_done: got %h, expected %h",
            $sampled(o_done), exp_done));

    initial begin
        #((N_STEPS * 10 + 50) * 10);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        i_rstn  = 1'b0;
        i_start = 1'b0;
        i_act   = ACT_NONE;
        set_base();
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        i_rstn = 1'b1;
        assert (!o_valid && !o_done && o_player == '0 && o_bullets == '0
                && o_enemies == '0 && o_divers == '0 && o_score == '0)
            else fail_now("outputs not cleared after reset");

        // every action code and then the screen limits
        for (int a = 0; a < 8; a++) run_step(act_e'(a));
        i_player.x = 8'd0;
        run_step(ACT_LEFT);
        i_player.x = 8'd200;
        run_step(ACT_RIGHT);
        i_player.y = 8'd0;
        run_step(ACT_UP);
        i_player.y = 8'd150;
        run_step(ACT_DOWN);

        set_base();
        i_bullets[0] = mk_obj(10, 20, 0, 1);
        i_bullets[2] = mk_obj(30, 40, 1, 1);
        run_step(ACT_FIRE_RIGHT);   // lands in slot 1
        for (int k = 0; k < NB; k++) i_bullets[k] = mk_obj(20 * k + 5, 60, k % 2, 1);
        run_step(ACT_FIRE_LEFT);    // no room
        i_bullets  = '0;
        i_player.x = 8'd1;
        run_step(ACT_FIRE_LEFT);    // x wraps
        i_bullets[0] = mk_obj(0, 30, 1, 1);
        i_bullets[1] = mk_obj(210, 30, 0, 1);
        i_bullets[2] = mk_obj(209, 30, 0, 1);
        i_enemies[0] = mk_obj(0, 90, 1, 1);
        i_enemies[1] = mk_obj(250, 90, 0, 1);
        i_divers[0]  = mk_obj(1, 120, 1, 1);
        run_step(ACT_NONE);

        // hits with the box edge excluded
        set_base();
        i_enemies[0] = mk_obj(50, 50, 0, 1);
        i_bullets[0] = mk_obj(50, 55, 0, 1);
        i_bullets[1] = mk_obj(55, 55, 0, 1);
        i_bullets[2] = mk_obj(56, 56, 0, 1);
        i_enemies[1] = mk_obj(80, 50, 1, 1);
        i_bullets[3] = mk_obj(88, 52, 1, 1);
        run_step(ACT_NONE);

        set_base();
        i_player.divc = 3'd5;       // second pickup saturates
        i_divers[0]   = mk_obj(99, 85, 0, 1);
        i_divers[1]   = mk_obj(108, 89, 0, 1);
        i_divers[2]   = mk_obj(109, 85, 0, 1);
        i_divers[3]   = mk_obj(104, 79, 0, 1);
        run_step(ACT_NONE);

        set_base();
        i_player.y      = 8'd5;
        i_player.divc   = 3'd6;
        i_player.oxygen = 10'd3;
        run_step(ACT_NONE);
        i_player.y = 8'd10;
        run_step(ACT_UP);           // surfaces by moving
        set_base();
        i_player.oxygen = 10'd1;
        i_player.lives  = 3'd2;
        run_step(ACT_NONE);
        i_player.oxygen = 10'd0;
        i_player.lives  = 3'd1;
        run_step(ACT_NONE);         // last life
        set_base();
        run_step(ACT_RIGHT);        // done must hold

        for (int s = 0; s < N_RANDOM; s++) begin
            i_player.x      = 8'(xorshift32() % 32'd206);
            i_player.y      = 8'(xorshift32() % 32'd160);
            i_player.oxygen = (xorshift32() % 8 == 0) ? 10'(xorshift32() % 3)
                                                      : 10'(xorshift32() % 1000);
            i_player.lives  = 3'(xorshift32());
            i_player.divc   = 3'(xorshift32() % 7);
            for (int k = 0; k < NB; k++) i_bullets[k] = near_obj(i_player);
            for (int k = 0; k < NE; k++) i_enemies[k] = near_obj(i_player);
            for (int k = 0; k < ND; k++) i_divers[k] = near_obj(i_player);
            i_score = xorshift32();
            run_step(act_e'(3'(xorshift32())));
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: design/game_step.sv
`timescale 1ns/1ns

module game_step #(
    parameter int N_BULLETS = 5,
    parameter int N_ENEMIES = 5,
    parameter int N_DIVERS  = 5
) (
    input  logic                                i_clk,
    input  logic                                i_rstn,
    input  logic                                i_start,
    input  game_pkg::act_e                      i_act,
    input  game_pkg::player_t                   i_player,
    input  game_pkg::obj_t [N_BULLETS-1:0]      i_bullets,
    input  game_pkg::obj_t [N_ENEMIES-1:0]      i_enemies,
    input  game_pkg::obj_t [N_DIVERS-1:0]       i_divers,
    input  logic [31:0]                         i_score,
    output game_pkg::player_t                   o_player,
    output game_pkg::obj_t [N_BULLETS-1:0]      o_bullets,
    output game_pkg::obj_t [N_ENEMIES-1:0]      o_enemies,
    output game_pkg::obj_t [N_DIVERS-1:0]       o_divers,
    output logic [31:0]                         o_score,
    output logic                                o_done,
    output logic                                o_valid
);
    import game_pkg::*;

    logic                 move_en;
    logic                 resolve_en;
    player_t              moved_player;
    logic [N_BULLETS-1:0] bullet_active;
    logic [N_BULLETS-1:0] shot_sel;
    obj_t                 shot;
    obj_t [N_BULLETS-1:0] moved_bullets;
    obj_t [N_ENEMIES-1:0] moved_enemies;
    obj_t [N_DIVERS-1:0]  moved_divers;

    step_control step_control_i (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_start      (i_start),
        .o_move_en    (move_en),
        .o_resolve_en (resolve_en),
        .o_valid      (o_valid)
    );

    player_action #(.N_BULLETS(N_BULLETS)) player_action_i (
        .i_clk           (i_clk),
        .i_rstn          (i_rstn),
        .i_move_en       (move_en),
        .i_act           (i_act),
        .i_player        (i_player),
        .i_bullet_active (bullet_active),
        .o_player        (moved_player),
        .o_shot_sel      (shot_sel),
        .o_shot          (shot)
    );

    for (genvar g = 0; g < N_BULLETS; g++) begin : g_bullet
        assign bullet_active[g] = i_bullets[g].active;
        object_lane lane_i (.i_clk(i_clk), .i_rstn(i_rstn), .i_load_en(move_en),
            .i_obj(i_bullets[g]), .i_spawn_sel(shot_sel[g]), .i_spawn(shot),
            .o_obj(moved_bullets[g]));
    end

    // enemies and divers never spawn here
    for (genvar g = 0; g < N_ENEMIES; g++) begin : g_enemy
        object_lane lane_i (.i_clk(i_clk), .i_rstn(i_rstn), .i_load_en(move_en),
            .i_obj(i_enemies[g]), .i_spawn_sel(1'b0), .i_spawn('0),
            .o_obj(moved_enemies[g]));
    end

    for (genvar g = 0; g < N_DIVERS; g++) begin : g_diver
        object_lane lane_i (.i_clk(i_clk), .i_rstn(i_rstn), .i_load_en(move_en),
            .i_obj(i_divers[g]), .i_spawn_sel(1'b0), .i_spawn('0),
            .o_obj(moved_divers[g]));
    end

    collision_score #(
        .N_BULLETS (N_BULLETS),
        .N_ENEMIES (N_ENEMIES),
        .N_DIVERS  (N_DIVERS)
    ) collision_score_i (
        .i_clk        (i_clk),
        .i_rstn       (i_rstn),
        .i_resolve_en (resolve_en),
        .i_player     (moved_player),
        .i_bullets    (moved_bullets),
        .i_enemies    (moved_enemies),
        .i_divers     (moved_divers),
        .i_score      (i_score),
        .o_player     (o_player),
        .o_bullets    (o_bullets),
        .o_enemies    (o_enemies),
        .o_divers     (o_divers),
        .o_score      (o_score),
        .o_done       (o_done)
    );

endmodule

// File: design/collision/collision_score.sv
`timescale 1ns/1ns

module collision_score #(
    parameter int N_BULLETS = 5,
    parameter int N_ENEMIES = 5,
    parameter int N_DIVERS  = 5
) (
    input  logic                                i_clk,
    input  logic                                i_rstn,
    input  logic                                i_resolve_en,
    input  game_pkg::player_t                   i_player,
    input  game_pkg::obj_t [N_BULLETS-1:0]      i_bullets,
    input  game_pkg::obj_t [N_ENEMIES-1:0]      i_enemies,
    input  game_pkg::obj_t [N_DIVERS-1:0]       i_divers,
    input  logic [31:0]                         i_score,
    output game_pkg::player_t                   o_player,
    output game_pkg::obj_t [N_BULLETS-1:0]      o_bullets,
    output game_pkg::obj_t [N_ENEMIES-1:0]      o_enemies,
    output game_pkg::obj_t [N_DIVERS-1:0]       o_divers,
    output logic [31:0]                         o_score,
    output logic                                o_done
);
    import game_pkg::*;

    player_t              player_d;
    obj_t [N_BULLETS-1:0] bullets_d;
    obj_t [N_ENEMIES-1:0] enemies_d;
    obj_t [N_DIVERS-1:0]  divers_d;
    logic [31:0]          gain;
    logic                 lose;

    always_comb begin
        player_d  = i_player;
        bullets_d = i_bullets;
        enemies_d = i_enemies;
        divers_d  = i_divers;
        gain      = '0;
        lose      = 1'b0;

        // enemy order first, then lowest bullet; a dead enemy stops matching
        for (int e = 0; e < N_ENEMIES; e++) begin
            for (int b = 0; b < N_BULLETS; b++) begin
                if (enemies_d[e].active && bullets_d[b].active
                        && bullets_d[b].x > enemies_d[e].x
                        && bullets_d[b].x < enemies_d[e].x + ENEMY_SIZE
                        && bullets_d[b].y > enemies_d[e].y
                        && bullets_d[b].y < enemies_d[e].y + ENEMY_SIZE) begin
                    enemies_d[e].active = 1'b0;
                    bullets_d[b].active = 1'b0;
                    gain = gain + SHOT_REWARD;
                end
            end
        end

        for (int d = 0; d < N_DIVERS; d++) begin
            if (divers_d[d].active
                    && divers_d[d].x >= i_player.x
                    && divers_d[d].x < i_player.x + PLAYER_SIZE
                    && divers_d[d].y >= i_player.y
                    && divers_d[d].y < i_player.y + PLAYER_SIZE) begin
                divers_d[d].active = 1'b0;
                gain = gain + DIVER_REWARD;
                if (player_d.divc < 3'(MAX_DIVERS_HELD)) begin
                    player_d.divc = player_d.divc + 3'd1;
                end
            end
        end

        if (i_player.y < SURFACE_Y) begin
            player_d.oxygen = 10'(MAX_OXYGEN);
            if (i_player.divc == 3'(MAX_DIVERS_HELD)) begin  // full load delivered
                player_d.divc = 3'd0;
                gain = gain + RESCUE_REWARD;
            end
        end else if (i_player.oxygen <= 10'd1) begin
            player_d.oxygen = 10'(MAX_OXYGEN);
            if (i_player.lives <= 3'd1) begin
                player_d.lives = 3'd0;
                lose = 1'b1;
            end else begin
                player_d.lives = i_player.lives - 3'd1;
            end
        end else begin
            player_d.oxygen = i_player.oxygen - 10'd1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_player  <= '0;
            o_bullets <= '0;
            o_enemies <= '0;
            o_divers  <= '0;
            o_score   <= '0;
            o_done    <= 1'b0;
        end else if (i_resolve_en) begin
            o_player  <= player_d;
            o_bullets <= bullets_d;
            o_enemies <= enemies_d;
            o_divers  <= divers_d;
            o_score   <= i_score + gain;
            o_done    <= o_done | lose; // held until reset
        end
    end

endmodule

// File: design/object_lane.sv
`timescale 1ns/1ns

module object_lane (
    input  logic           i_clk,
    input  logic           i_rstn,
    input  logic           i_load_en,
    input  game_pkg::obj_t i_obj,
    input  logic           i_spawn_sel,
    input  game_pkg::obj_t i_spawn,
    output game_pkg::obj_t o_obj
);
    import game_pkg::*;

    obj_t obj_d;

    always_comb begin
        obj_d = i_obj;
        if (i_spawn_sel) begin
            obj_d = i_spawn;    // new shot takes the slot this step
        end else if (i_obj.active) begin
            if (i_obj.dir) begin
                if (i_obj.x == 8'd0) obj_d.active = 1'b0;
                else obj_d.x = i_obj.x - 8'd1;
            end else begin
                if (i_obj.x >= SCREEN_WIDTH) obj_d.active = 1'b0;
                else obj_d.x = i_obj.x + 8'd1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_obj <= '0;
        end else if (i_load_en) begin
            o_obj <= obj_d;
        end
    end

endmodule

// File: design/player_action.sv
`timescale 1ns/1ns

module player_action #(
    parameter int N_BULLETS = 5
) (
    input  logic                  i_clk,
    input  logic                  i_rstn,
    input  logic                  i_move_en,
    input  game_pkg::act_e        i_act,
    input  game_pkg::player_t     i_player,
    input  logic [N_BULLETS-1:0]  i_bullet_active,
    output game_pkg::player_t     o_player,
    output logic [N_BULLETS-1:0]  o_shot_sel,
    output game_pkg::obj_t        o_shot
);
    import game_pkg::*;

    player_t              player_d;
    logic [N_BULLETS-1:0] free_sel;
    logic                 fire;

    always_comb begin
        player_d = i_player;
        case (i_act)
            ACT_LEFT: begin
                if (i_player.x > 8'd0) player_d.x = i_player.x - 8'd1;
            end
            ACT_RIGHT: begin
                if (i_player.x + PLAYER_SIZE < SCREEN_WIDTH) player_d.x = i_player.x + 8'd1;
            end
            ACT_UP: begin
                if (i_player.y > 8'd0) player_d.y = i_player.y - 8'd1;
            end
            ACT_DOWN: begin
                if (i_player.y + PLAYER_SIZE < SCREEN_HEIGHT) player_d.y = i_player.y + 8'd1;
            end
            default: player_d = i_player;
        endcase
    end

    // lowest clear bit of the active mask, zero when all slots are busy
    assign free_sel = ~i_bullet_active & (i_bullet_active + 1'b1);

    assign fire       = (i_act == ACT_FIRE_LEFT) || (i_act == ACT_FIRE_RIGHT);
    assign o_shot_sel = fire ? free_sel : '0;

    always_comb begin
        o_shot.y      = i_player.y;
        o_shot.active = 1'b1;
        o_shot.dir    = (i_act == ACT_FIRE_LEFT);
        o_shot.x      = o_shot.dir ? i_player.x - 8'd2 : i_player.x + 8'd2; // wraps
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            o_player <= '0;
        end else if (i_move_en) begin
            o_player <= player_d;
        end
    end

endmodule

// File: design/step_control.sv
`timescale 1ns/1ns

module step_control (
    input  logic i_clk,
    input  logic i_rstn,
    input  logic i_start,
    output logic o_move_en,
    output logic o_resolve_en,
    output logic o_valid
);
    import game_pkg::*;

    phase_e phase_q;
    phase_e phase_d;
    logic   valid_q;

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: begin
                if (i_start) begin
                    phase_d = PH_MOVE;
                end
            end
            PH_MOVE:    phase_d = PH_RESOLVE;
            PH_RESOLVE: phase_d = PH_IDLE;  // start is dropped here
            default:    phase_d = PH_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            phase_q <= PH_IDLE;
            valid_q <= 1'b0;
        end else begin
            phase_q <= phase_d;
            valid_q <= o_resolve_en; // high the cycle after the resolve edge
        end
    end

    assign o_move_en    = (phase_q == PH_IDLE) && i_start;
    assign o_resolve_en = (phase_q == PH_MOVE);
    assign o_valid      = valid_q;

endmodule

// File: common/game_pkg.sv
package game_pkg;

    // playfield limits in pixels
    localparam int unsigned SCREEN_WIDTH  = 210;
    localparam int unsigned SCREEN_HEIGHT = 160;

    // hit box edges
    localparam int unsigned PLAYER_SIZE = 10;
    localparam int unsigned ENEMY_SIZE  = 10;

    localparam int unsigned SURFACE_Y = 10; // rows above this count as surface

    localparam int unsigned MAX_OXYGEN      = 1000;
    localparam int unsigned MAX_DIVERS_HELD = 6;

    // score increments
    localparam int unsigned SHOT_REWARD   = 20;
    localparam int unsigned DIVER_REWARD  = 50;
    localparam int unsigned RESCUE_REWARD = 50;

    // bullet, enemy or diver slot
    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
        logic       dir;    // 1 moves left
        logic       active;
    } obj_t;

    typedef struct packed {
        logic [7:0] x;
        logic [7:0] y;
        logic [9:0] oxygen;
        logic [2:0] lives;
        logic [2:0] divc;   // divers currently held
    } player_t;

    // 000 and 111 leave the player alone
    typedef enum logic [2:0] {
        ACT_NONE       = 3'b000,
        ACT_LEFT       = 3'b001,
        ACT_RIGHT      = 3'b010,
        ACT_UP         = 3'b100,
        ACT_DOWN       = 3'b011,
        ACT_FIRE_LEFT  = 3'b101,
        ACT_FIRE_RIGHT = 3'b110
    } act_e;

    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_MOVE    = 2'd1,
        PH_RESOLVE = 2'd2
    } phase_e;

endpackage
